//--- project.f
verilog/rv_core_pkg.sv
verilog/rv_pc_unit.sv
verilog/rv_control.sv
verilog/rv_regfile.sv
verilog/rv_imm_gen.sv
verilog/rv_alu.sv
verilog/rv_load_store.sv
verilog/rv_core.sv
tb/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_pc_unit.sv
  - verilog/rv_control.sv
  - verilog/rv_regfile.sv
  - verilog/rv_imm_gen.sv
  - verilog/rv_alu.sv
  - verilog/rv_load_store.sv
  - verilog/rv_core.sv
  - target: simulation
    files:
      - tb/rv_core_tb.sv

//--- tb/rv_core_tb.sv
/*
 * Testbench for the RV32I single-cycle core
 * Runs a hand-assembled program from a table and checks each store and jump target
 */
module rv_core_tb import rv_core_pkg::*; ();

    localparam int    SEED         = 32885;
    localparam int    MAX_ROWS     = 256;
    localparam int    DMEM_WORDS   = 1024;
    localparam int    RESET_CYCLES = 10;
    localparam word_t NOP          = 32'h0000_0013;

    logic     clk;
    logic     rst_n;
    word_t    imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
    byte_en_t dmem_be;
    logic     dmem_we;

    // Program table with one row per instruction word
    word_t    row_instr  [0:MAX_ROWS-1];
    word_t    row_addr   [0:MAX_ROWS-1];
    word_t    row_data   [0:MAX_ROWS-1];
    byte_en_t row_be     [0:MAX_ROWS-1];
    int       row_grp    [0:MAX_ROWS-1];
    logic     row_jump   [0:MAX_ROWS-1];
    word_t    row_target [0:MAX_ROWS-1];
    // Rows whose store must happen in execution order
    int       exp_rows   [0:MAX_ROWS-1];
    int       n_rows, n_exp;

    word_t model [0:31];
    word_t imem  [0:MAX_ROWS-1];
    word_t dmem  [0:DMEM_WORDS-1];
    word_t slot_addr;

    int    n_checked, n_pass, n_fail, cycles, limit;
    logic  jump_pending;
    word_t jump_target;
    word_t halt_pc;

    rv_core #(.RESET_ADDR(32'h0)) u_rv_core (
        .clk(clk), .rst_n(rst_n), .o_imem_addr(imem_addr), .i_imem_data(imem_data),
        .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata), .o_dmem_be(dmem_be),
        .o_dmem_we(dmem_we), .i_dmem_rdata(dmem_rdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Combinational memories that feed a no-op word during reset
    assign imem_data  = rst_n ? imem[imem_addr[9:2]] : NOP;
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b]) begin
                    dmem[dmem_addr[11:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                    input opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Reference results of the RV32I integer operations
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1:       return "alu";
            2:       return "upper imm";
            3:       return "branch";
            4:       return "jump";
            5:       return "store lanes";
            default: return "load";
        endcase
    endfunction

    function automatic word_t pc_now();
        return word_t'(n_rows * 4);
    endfunction

    task automatic emit(input word_t instr);
        row_instr[n_rows] = instr;
        row_jump[n_rows]  = 1'b0;
        n_rows++;
    endtask

    task automatic emit_store(input word_t instr, input word_t addr, input word_t data,
                              input byte_en_t be, input int grp);
        exp_rows[n_exp]  = n_rows;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_be[n_rows]   = be;
        row_grp[n_rows]  = grp;
        n_exp++;
        emit(instr);
    endtask

    task automatic emit_jump(input word_t instr, input word_t target);
        row_target[n_rows] = target;
        emit(instr);
        row_jump[n_rows-1] = 1'b1;
    endtask

    // Store that must never execute
    task automatic poison();
        emit(enc_s(12'h7f0, 5'd3, 5'd0, 3'b010));
    endtask

    task automatic store_result(input reg_addr_t rs2, input int grp);
        emit_store(enc_s(slot_addr[11:0], rs2, 5'd0, 3'b010), slot_addr, model[rs2],
                   4'b1111, grp);
        slot_addr = slot_addr + 4;
    endtask

    // LUI plus ADDI with the upper part rounded for the signed low part
    task automatic li(input reg_addr_t rd, input word_t val);
        word_t hi;
        hi = val - sext12(val[11:0]);
        emit(enc_u(hi[31:12], rd, OP_LUI));
        emit(enc_i(val[11:0], rd, 3'b000, rd, OP_IMM));
        model[rd] = val;
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [11:0] imm);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OP_IMM));
        model[3] = alu_ref(f3, f3 == 3'b101 && imm[10], model[1], sext12(imm));
        store_result(5'd3, 1);
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic alt);
        emit({1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, OP_REG});
        model[3] = alu_ref(f3, alt, model[1], model[2]);
        store_result(5'd3, 1);
    endtask

    // Taken branches skip the marker store right behind them
    task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2);
        logic taken;
        taken = branch_ref(f3, model[rs1], model[rs2]);
        emit(enc_b(13'd8, rs2, rs1, f3));
        if (taken) begin
            emit(enc_s(slot_addr[11:0], 5'd3, 5'd0, 3'b010));
            slot_addr = slot_addr + 4;
        end else begin
            store_result(5'd3, 3);
        end
    endtask

    task automatic load_case(input logic [2:0] f3, input int off, input word_t known);
        word_t sel, a;
        sel = known >> (8 * off);
        a   = 32'h200 + off;
        emit(enc_i(a[11:0], 5'd0, f3, 5'd8, OP_LOAD));
        case (f3)
            3'b000:  model[8] = {{24{sel[7]}}, sel[7:0]};
            3'b001:  model[8] = {{16{sel[15]}}, sel[15:0]};
            3'b100:  model[8] = {24'b0, sel[7:0]};
            default: model[8] = {16'b0, sel[15:0]};
        endcase
        store_result(5'd8, 6);
    endtask

    task automatic build_program();
        word_t       r1, r2, tmp, a, target, link;
        logic [11:0] imm_a, imm_b;
        logic [4:0]  sh;
        logic [2:0]  f3;
        r1  = $urandom;
        r2  = $urandom;
        // Opposite signs separate the signed and unsigned compares
        r1[31] = 1'b1;
        r2[31] = 1'b0;
        // Negative r1 and odd shift amounts tell arithmetic from logical shifts
        r2[0]  = 1'b1;
        tmp   = $urandom;
        imm_a = tmp[11:0];
        imm_b = tmp[23:12];
        sh    = tmp[28:24] | 5'd1;
        li(5'd1, r1);
        li(5'd2, r2);
        alu_imm(3'b000, imm_a);
        alu_imm(3'b100, imm_b);
        alu_imm(3'b110, imm_a);
        alu_imm(3'b111, imm_b);
        alu_imm(3'b010, imm_a);
        alu_imm(3'b011, imm_b);
        alu_imm(3'b001, {7'b0, sh});
        alu_imm(3'b101, {7'b0, sh});
        alu_imm(3'b101, {7'b0100000, sh});
        for (int k = 0; k < 8; k++) begin
            f3 = k[2:0];
            alu_reg(f3, 1'b0);
        end
        alu_reg(3'b000, 1'b1);
        alu_reg(3'b101, 1'b1);
        tmp = $urandom;
        emit(enc_u(tmp[19:0], 5'd4, OP_LUI));
        model[4] = {tmp[19:0], 12'b0};
        store_result(5'd4, 2);
        tmp = $urandom;
        model[4] = pc_now() + {tmp[19:0], 12'b0};
        emit(enc_u(tmp[19:0], 5'd4, OP_AUIPC));
        store_result(5'd4, 2);
        // Equal pair plus both orders of the unequal pair
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) begin
                continue;
            end
            f3 = k[2:0];
            branch_case(f3, 5'd1, 5'd1);
            branch_case(f3, 5'd1, 5'd2);
            branch_case(f3, 5'd2, 5'd1);
        end
        model[10] = pc_now() + 4;
        emit_jump(enc_j(21'd12, 5'd10), pc_now() + 12);
        poison();
        poison();
        store_result(5'd10, 4);
        // JALR base is odd after the offset so bit 0 gets cleared
        link   = pc_now() + 12;
        target = pc_now() + 20;
        li(5'd5, target - 3);
        emit_jump(enc_i(12'd4, 5'd5, 3'b000, 5'd11, OP_JALR), target);
        model[11] = link;
        poison();
        poison();
        store_result(5'd11, 4);
        li(5'd6, $urandom);
        for (int k = 0; k < 4; k++) begin
            a = 32'h700 + k;
            emit_store(enc_s(a[11:0], 5'd6, 5'd0, 3'b000), a, {4{model[6][7:0]}},
                       byte_en_t'(4'b0001 << k), 5);
        end
        emit_store(enc_s(12'h708, 5'd6, 5'd0, 3'b001), 32'h708, {2{model[6][15:0]}}, 4'b0011, 5);
        emit_store(enc_s(12'h70a, 5'd6, 5'd0, 3'b001), 32'h70a, {2{model[6][15:0]}}, 4'b1100, 5);
        li(5'd7, 32'h7a8f_f10c);
        emit_store(enc_s(12'h200, 5'd7, 5'd0, 3'b010), 32'h200, model[7], 4'b1111, 6);
        for (int k = 0; k < 4; k++) begin
            load_case(3'b000, k, model[7]);
            load_case(3'b100, k, model[7]);
        end
        for (int k = 0; k < 4; k += 2) begin
            load_case(3'b001, k, model[7]);
            load_case(3'b101, k, model[7]);
        end
    endtask

    // Store and jump target checks sampled before the edge updates the core
    always @(posedge clk) begin
        int r;
        if (rst_n) begin
            if (jump_pending) begin
                if (imem_addr !== jump_target) begin
                    $display("mismatch at %0t: jump landed at %h, expected %h",
                             $time, imem_addr, jump_target);
                    $display("jump to %h: fail", jump_target);
                    n_fail++;
                end else begin
                    $display("jump to %h: pass", jump_target);
                    n_pass++;
                end
            end
            jump_pending = row_jump[imem_addr[9:2]];
            jump_target  = row_target[imem_addr[9:2]];
            if (dmem_we) begin
                if (n_checked >= n_exp) begin
                    $display("unexpected store to address %h at time %0t", dmem_addr, $time);
                    n_fail++;
                end else begin
                    r = exp_rows[n_checked];
                    if (dmem_addr !== row_addr[r] || dmem_wdata !== row_data[r] ||
                        dmem_be !== row_be[r]) begin
                        $display("mismatch at %0t: store got %h/%h/%b, expected %h/%h/%b",
                                 $time, dmem_addr, dmem_wdata, dmem_be,
                                 row_addr[r], row_data[r], row_be[r]);
                        $display("test %0d (%s): fail", n_checked, group_name(row_grp[r]));
                        n_fail++;
                    end else begin
                        $display("test %0d (%s): pass", n_checked, group_name(row_grp[r]));
                        n_pass++;
                    end
                    n_checked++;
                end
            end
        end
    end

    initial begin
        int seed_ret;
        seed_ret     = $urandom(SEED);
        rst_n        = 1'b0;
        n_rows       = 0;
        n_exp        = 0;
        n_checked    = 0;
        n_pass       = 0;
        n_fail       = 0;
        jump_pending = 1'b0;
        jump_target  = '0;
        slot_addr    = 32'h400;
        for (int i = 0; i < MAX_ROWS; i++) begin
            row_jump[i]   = 1'b0;
            row_target[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        build_program();
        // Halt loop jumps to itself
        halt_pc = pc_now();
        emit(enc_j(21'd0, 5'd0));
        for (int i = 0; i < MAX_ROWS; i++) begin
            imem[i] = (i < n_rows) ? row_instr[i] : NOP;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hc0de_0000 ^ (i * 32'h0001_9e37);
        end
        limit = 4 * n_rows + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        cycles = RESET_CYCLES;
        while (imem_addr != halt_pc && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (imem_addr != halt_pc) begin
            $display("timeout: the program did not reach its halt loop in %0d cycles", limit);
            n_fail++;
        end else if (n_checked != n_exp) begin
            $display("program ended after %0d of %0d expected stores", n_checked, n_exp);
            n_fail++;
        end
        $display("summary: %0d checks passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/rv_core.sv
/*
 * RV32I single-cycle core
 * Wires PC, decoder, register file, ALU, target adder and lane logic
 * to a combinational instruction port and a strobed data port
 */
module rv_core import rv_core_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    o_imem_addr,
    input  word_t    i_imem_data,
    output word_t    o_dmem_addr,
    output word_t    o_dmem_wdata,
    output byte_en_t o_dmem_be,
    output logic     o_dmem_we,
    input  word_t    i_dmem_rdata
);

    word_t           pc, pc_plus4, target;
    word_t           rdata1, rdata2, imm, alu_src2, alu_result;
    word_t           load_data, wb_data;
    reg_addr_t       rs1, rs2, rd;
    logic [2:0]      funct3;
    logic            alu_zero, alu_last_bit, reg_write, mem_write;
    alu_op_t         alu_op;
    imm_src_t        imm_src;
    alu_src_t        alu_src;
    wb_src_t         wb_src;
    pc_src_t         pc_src;
    second_add_src_t second_add_src;

    assign rs1    = i_imem_data[19:15];
    assign rs2    = i_imem_data[24:20];
    assign rd     = i_imem_data[11:7];
    assign funct3 = i_imem_data[14:12];

    rv_pc_unit #(.RESET_ADDR(RESET_ADDR)) u_pc_unit (
        .clk(clk), .rst_n(rst_n), .i_pc_src(pc_src), .i_target(target),
        .o_pc(pc), .o_pc_plus4(pc_plus4)
    );

    rv_control u_control (
        .i_instr(i_imem_data), .i_alu_zero(alu_zero), .i_alu_last_bit(alu_last_bit),
        .o_alu_op(alu_op), .o_imm_src(imm_src), .o_alu_src(alu_src),
        .o_wb_src(wb_src), .o_pc_src(pc_src), .o_second_add_src(second_add_src),
        .o_reg_write(reg_write), .o_mem_write(mem_write)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(reg_write), .i_wdata(wb_data), .o_rdata1(rdata1), .o_rdata2(rdata2)
    );

    rv_imm_gen u_imm_gen (.i_instr(i_imem_data), .i_imm_src(imm_src), .o_imm(imm));

    assign alu_src2 = (alu_src == ALU_SRC_IMM) ? imm : rdata2;

    rv_alu u_alu (
        .i_op(alu_op), .i_src1(rdata1), .i_src2(alu_src2),
        .o_result(alu_result), .o_zero(alu_zero), .o_last_bit(alu_last_bit)
    );

    // Target adder for branches, jumps and upper immediates
    always_comb begin
        case (second_add_src)
            SA_SRC_PC:   target = pc + imm;
            SA_SRC_ZERO: target = imm;
            // JALR drops bit 0 of the sum
            SA_SRC_REG1: target = (rdata1 + imm) & ~word_t'(1);
            default:     target = pc_plus4;
        endcase
    end

    rv_load_store u_load_store (
        .i_funct3(funct3), .i_addr_low(alu_result[1:0]), .i_store_data(rdata2),
        .i_mem_rdata(i_dmem_rdata), .o_be(o_dmem_be), .o_wdata(o_dmem_wdata),
        .o_load_data(load_data)
    );

    always_comb begin
        case (wb_src)
            WB_LOAD:       wb_data = load_data;
            WB_PC_PLUS4:   wb_data = pc_plus4;
            WB_SECOND_ADD: wb_data = target;
            default:       wb_data = alu_result;
        endcase
    end

    assign o_imem_addr = pc;
    assign o_dmem_addr = alu_result;
    assign o_dmem_we   = mem_write;

endmodule

//--- verilog/rv_load_store.sv
/*
 * Load/store lane logic
 * Store side sets byte enables and replicates data into the lanes,
 * load side picks the addressed byte or halfword and extends it
 */
module rv_load_store import rv_core_pkg::*; (
    input  logic [2:0] i_funct3,
    input  logic [1:0] i_addr_low,
    input  word_t      i_store_data,
    input  word_t      i_mem_rdata,
    output byte_en_t   o_be,
    output word_t      o_wdata,
    output word_t      o_load_data
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic        is_unsigned;

    // Store lanes
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                o_be    = byte_en_t'(4'b0001 << i_addr_low);
                o_wdata = {4{i_store_data[7:0]}};
            end
            2'b01: begin
                o_be    = i_addr_low[1] ? 4'b1100 : 4'b0011;
                o_wdata = {2{i_store_data[15:0]}};
            end
            2'b10: begin
                o_be    = 4'b1111;
                o_wdata = i_store_data;
            end
            default: begin
                o_be    = 4'b0000;
                o_wdata = i_store_data;
            end
        endcase
    end

    assign load_byte   = i_mem_rdata[8*i_addr_low +: 8];
    assign load_half   = i_addr_low[1] ? i_mem_rdata[31:16] : i_mem_rdata[15:0];
    assign is_unsigned = i_funct3[2];

    always_comb begin
        case (i_funct3[1:0])
            2'b00:   o_load_data = {{24{!is_unsigned && load_byte[7]}}, load_byte};
            2'b01:   o_load_data = {{16{!is_unsigned && load_half[15]}}, load_half};
            default: o_load_data = i_mem_rdata;
        endcase
    end

endmodule

//--- verilog/rv_alu.sv
/*
 * ALU
 * Ten integer operations with zero and bit-0 flags for branches
 */
module rv_alu import rv_core_pkg::*; (
    input  alu_op_t i_op,
    input  word_t   i_src1,
    input  word_t   i_src2,
    output word_t   o_result,
    output logic    o_zero,
    output logic    o_last_bit
);

    logic [4:0] shamt;

    assign shamt = i_src2[4:0];

    always_comb begin
        case (i_op)
            ALU_SUB:  o_result = i_src1 - i_src2;
            ALU_AND:  o_result = i_src1 & i_src2;
            ALU_OR:   o_result = i_src1 | i_src2;
            ALU_XOR:  o_result = i_src1 ^ i_src2;
            ALU_SLL:  o_result = i_src1 << shamt;
            ALU_SRL:  o_result = i_src1 >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_src1) >>> shamt);
            // Compare results land in bit 0
            ALU_SLT:  o_result = word_t'($signed(i_src1) < $signed(i_src2));
            ALU_SLTU: o_result = word_t'(i_src1 < i_src2);
            default:  o_result = i_src1 + i_src2;
        endcase
    end

    assign o_zero     = (o_result == '0);
    assign o_last_bit = o_result[0];

endmodule

//--- verilog/rv_imm_gen.sv
/*
 * Immediate generator
 * Builds the sign-extended immediate for the I, S, B, U and J formats
 */
module rv_imm_gen import rv_core_pkg::*; (
    input  word_t    i_instr,
    input  imm_src_t i_imm_src,
    output word_t    o_imm
);

    logic sign;

    assign sign = i_instr[31];

    always_comb begin
        case (i_imm_src)
            IMM_S:   o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            IMM_B:   o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                              i_instr[11:8], 1'b0};
            // Upper twenty bits, low part zero
            IMM_U:   o_imm = {i_instr[31:12], 12'b0};
            IMM_J:   o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                              i_instr[30:21], 1'b0};
            default: o_imm = {{20{sign}}, i_instr[31:20]};
        endcase
    end

endmodule

//--- verilog/rv_regfile.sv
/*
 * Register file
 * 31 writable registers, two combinational reads, one clocked write
 */
module rv_regfile import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t i_rs1,
    input  reg_addr_t i_rs2,
    input  reg_addr_t i_rd,
    input  logic      i_we,
    input  word_t     i_wdata,
    output word_t     o_rdata1,
    output word_t     o_rdata2
);

    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 is hardwired
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

//--- verilog/rv_control.sv
/*
 * Instruction decoder
 * Main decode per opcode, ALU decode per funct3/funct7, branch decision
 */
module rv_control import rv_core_pkg::*; (
    input  word_t           i_instr,
    input  logic            i_alu_zero,
    input  logic            i_alu_last_bit,
    output alu_op_t         o_alu_op,
    output imm_src_t        o_imm_src,
    output alu_src_t        o_alu_src,
    output wb_src_t         o_wb_src,
    output pc_src_t         o_pc_src,
    output second_add_src_t o_second_add_src,
    output logic            o_reg_write,
    output logic            o_mem_write
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7_alt;
    alu_op_t    funct_op;
    logic       is_branch, is_jump, take_branch;

    assign opcode     = i_instr[6:0];
    assign funct3     = i_instr[14:12];
    assign funct7_alt = i_instr[30];

    // ALU decode shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  funct_op = (opcode == OP_REG && funct7_alt) ? ALU_SUB : ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = funct7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
    end

    always_comb begin
        // Anything unrecognised falls through as a no-op
        o_alu_op         = ALU_ADD;
        o_imm_src        = IMM_I;
        o_alu_src        = ALU_SRC_IMM;
        o_wb_src         = WB_ALU;
        o_second_add_src = SA_SRC_PC;
        o_reg_write      = 1'b0;
        o_mem_write      = 1'b0;
        is_branch        = 1'b0;
        is_jump          = 1'b0;
        case (opcode)
            OP_LUI: begin
                o_imm_src        = IMM_U;
                o_wb_src         = WB_SECOND_ADD;
                o_second_add_src = SA_SRC_ZERO;
                o_reg_write      = 1'b1;
            end
            OP_AUIPC: begin
                o_imm_src   = IMM_U;
                o_wb_src    = WB_SECOND_ADD;
                o_reg_write = 1'b1;
            end
            OP_JAL: begin
                o_imm_src   = IMM_J;
                o_wb_src    = WB_PC_PLUS4;
                o_reg_write = 1'b1;
                is_jump     = 1'b1;
            end
            OP_JALR: begin
                o_wb_src         = WB_PC_PLUS4;
                o_second_add_src = SA_SRC_REG1;
                o_reg_write      = 1'b1;
                is_jump          = 1'b1;
            end
            OP_BRANCH: begin
                o_imm_src = IMM_B;
                o_alu_src = ALU_SRC_REG;
                is_branch = 1'b1;
                // Compare op follows the branch family
                case (funct3[2:1])
                    2'b00:   o_alu_op = ALU_SUB;
                    2'b10:   o_alu_op = ALU_SLT;
                    default: o_alu_op = ALU_SLTU;
                endcase
            end
            OP_LOAD: begin
                o_wb_src    = WB_LOAD;
                o_reg_write = 1'b1;
            end
            OP_STORE: begin
                o_imm_src   = IMM_S;
                o_mem_write = 1'b1;
            end
            OP_IMM: begin
                o_alu_op    = funct_op;
                o_reg_write = 1'b1;
            end
            OP_REG: begin
                o_alu_op    = funct_op;
                o_alu_src   = ALU_SRC_REG;
                o_reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // Branch sense from funct3, using zero for eq/ne and bit 0 for the compares
    always_comb begin
        case (funct3)
            3'b000:  take_branch = i_alu_zero;
            3'b001:  take_branch = !i_alu_zero;
            3'b100,
            3'b110:  take_branch = i_alu_last_bit;
            3'b101,
            3'b111:  take_branch = !i_alu_last_bit;
            default: take_branch = 1'b0;
        endcase
        o_pc_src = (is_jump || (is_branch && take_branch)) ? PC_TARGET : PC_PLUS4;
    end

endmodule

//--- verilog/rv_pc_unit.sv
/*
 * Program counter
 * Holds the PC and picks PC+4 or the computed target each cycle
 */
module rv_pc_unit import rv_core_pkg::*; #(
    parameter word_t RESET_ADDR = '0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  pc_src_t i_pc_src,
    input  word_t   i_target,
    output word_t   o_pc,
    output word_t   o_pc_plus4
);

    word_t pc;
    word_t pc_next;

    assign o_pc_plus4 = pc + word_t'(4);
    assign pc_next    = (i_pc_src == PC_TARGET) ? i_target : o_pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_pc = pc;

endmodule

//--- verilog/rv_core_pkg.sv
/*
 * RV32I core package
 * Shared widths, opcode values and the datapath select encodings
 */
package rv_core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      byte_en_t;
    typedef logic [6:0]      opcode_t;

    // Opcode classes handled by the core
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_src_t;

    typedef enum logic {
        ALU_SRC_REG, ALU_SRC_IMM
    } alu_src_t;

    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_PC_PLUS4, WB_SECOND_ADD
    } wb_src_t;

    typedef enum logic {
        PC_PLUS4, PC_TARGET
    } pc_src_t;

    // Base operand of the target adder
    typedef enum logic [1:0] {
        SA_SRC_PC, SA_SRC_ZERO, SA_SRC_REG1
    } second_add_src_t;

endpackage
